/* logic/calsoc_pkg.sv */
package calsoc_pkg;

	//////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////

	// Word RAM, top byte decoded
	localparam logic [31:0] ram_base  = 32'h0100_0000;
	localparam logic [31:0] ram_mask  = 32'hFF00_0000;

	// GPIO block, 64 byte window
	localparam logic [31:0] gpio_base = 32'h0200_0000;
	localparam logic [31:0] gpio_mask = 32'hFFFF_FFC0;

	// Measure unit, top byte decoded
	localparam logic [31:0] mu_base   = 32'h0500_0000;
	localparam logic [31:0] mu_mask   = 32'hFF00_0000;

	//////////////////////////////////////////////////
	// Slave sizes
	//////////////////////////////////////////////////

	localparam int ram_words  = 256;
	localparam int gpio_width = 8;

	// Measure unit register word offsets
	localparam logic [1:0] mu_reg_dac    = 2'd0;
	localparam logic [1:0] mu_reg_delay  = 2'd1;
	localparam logic [1:0] mu_reg_ctrl   = 2'd2;
	localparam logic [1:0] mu_reg_status = 2'd3;

	//////////////////////////////////////////////////
	// Measurement timing
	//////////////////////////////////////////////////

	localparam int dac_code_w   = 16;
	localparam int delay_code_w = 10;

	// wb_clk_i cycles per sclk half period
	localparam int spi_clk_div = 4;

	// DAC output settling after sync rises
	localparam int dac_settle_cycles = 3;

	// Delay-line strobe width, comparator sampled in the last cycle
	localparam int strobe_hold_cycles = 5;

endpackage

/* logic/wb_decoder.sv */
`timescale 1ns/10ps

module wb_decoder (
	input	logic			wb_clk_i,
	input	logic			rst_n_i,

	// Master side
	input	logic			wb_cyc_i,
	input	logic			wb_stb_i,
	input	logic [31:0]	wb_adr_i,
	output	logic [31:0]	wb_dat_o,
	output	logic			wb_ack_o,
	output	logic			wb_err_o,

	// RAM slave
	output	logic			ram_stb_o,
	input	logic [31:0]	ram_dat_i,
	input	logic			ram_ack_i,

	// GPIO slave
	output	logic			gpio_stb_o,
	input	logic [31:0]	gpio_dat_i,
	input	logic			gpio_ack_i,

	// Measure unit slave
	output	logic			mu_stb_o,
	input	logic [31:0]	mu_dat_i,
	input	logic			mu_ack_i
);

	import calsoc_pkg::*;

	logic ram_hit;
	logic gpio_hit;
	logic mu_hit;
	logic any_hit;
	logic req;
	logic err_q;

	// One-hot region match
	assign ram_hit  = (wb_adr_i & ram_mask)  == ram_base;
	assign gpio_hit = (wb_adr_i & gpio_mask) == gpio_base;
	assign mu_hit   = (wb_adr_i & mu_mask)   == mu_base;
	assign any_hit  = ram_hit | gpio_hit | mu_hit;

	assign req = wb_cyc_i & wb_stb_i;

	assign ram_stb_o  = req & ram_hit;
	assign gpio_stb_o = req & gpio_hit;
	assign mu_stb_o   = req & mu_hit;

	// Return path, zero when nothing matches
	assign wb_dat_o = ({32{ram_hit}}  & ram_dat_i)
	                | ({32{gpio_hit}} & gpio_dat_i)
	                | ({32{mu_hit}}   & mu_dat_i);

	assign wb_ack_o = (ram_hit & ram_ack_i) | (gpio_hit & gpio_ack_i) | (mu_hit & mu_ack_i);

	// Unmapped access answers itself one cycle later
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req & ~any_hit & ~err_q;
		end
	end

	assign wb_err_o = err_q;

	a_one_slave: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		$onehot0({ram_stb_o, gpio_stb_o, mu_stb_o}));

endmodule

/* logic/wb_ram.sv */
`timescale 1ns/10ps

module wb_ram (
	input	logic			wb_clk_i,
	input	logic			rst_n_i,

	input	logic			stb_i,
	input	logic			we_i,
	input	logic [31:0]	adr_i,
	input	logic [31:0]	dat_i,
	input	logic [3:0]		sel_i,
	output	logic [31:0]	dat_o,
	output	logic			ack_o
);

	import calsoc_pkg::*;

	localparam int aw = $clog2(ram_words);

	logic [31:0]	mem [ram_words];
	logic [aw-1:0]	idx;
	logic			req;

	// Byte address to word index
	assign idx = adr_i[aw+1:2];
	assign req = stb_i & ~ack_o;

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req;
		end
	end

	// Storage and read port
	always_ff @(posedge wb_clk_i) begin
		if (req) begin
			dat_o <= mem[idx];
			if (we_i) begin
				for (int b = 0; b < 4; b++) begin
					if (sel_i[b])
						mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
				end
			end
		end
	end

	a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		ack_o |=> !ack_o);

endmodule

/* logic/gpio_regs.sv */
`timescale 1ns/10ps

module gpio_regs (
	input	logic								wb_clk_i,
	input	logic								rst_n_i,

	input	logic								stb_i,
	input	logic								we_i,
	input	logic [31:0]						adr_i,
	input	logic [31:0]						dat_i,
	input	logic [3:0]							sel_i,
	output	logic [31:0]						dat_o,
	output	logic								ack_o,

	input	logic [calsoc_pkg::gpio_width-1:0]	gpio_i,
	output	logic [calsoc_pkg::gpio_width-1:0]	gpio_o
);

	import calsoc_pkg::*;

	logic [gpio_width-1:0]	gpio_meta;
	logic [gpio_width-1:0]	gpio_sync;
	logic [3:0]				word;
	logic					req;

	assign word = adr_i[5:2];
	assign req  = stb_i & ~ack_o;

	// Two-flop input synchronizer
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gpio_meta <= '0;
			gpio_sync <= '0;
		end else begin
			gpio_meta <= gpio_i;
			gpio_sync <= gpio_meta;
		end
	end

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o  <= 1'b0;
			dat_o  <= '0;
			gpio_o <= '0;
		end else begin
			ack_o <= req;
			// Only word 0 is writable, lane 0 carries the pins
			if (req && we_i && word == 4'd0 && sel_i[0])
				gpio_o <= dat_i[gpio_width-1:0];
			if (req && !we_i) begin
				case (word)
					4'd0:    dat_o <= 32'(gpio_o);
					4'd1:    dat_o <= 32'(gpio_sync);
					default: dat_o <= '0;
				endcase
			end
		end
	end

endmodule

/* logic/dac_spi.sv */
`timescale 1ns/10ps

module dac_spi (
	input	logic								wb_clk_i,
	input	logic								rst_n_i,

	input	logic								load_i,
	input	logic [calsoc_pkg::dac_code_w-1:0]	code_i,
	output	logic								busy_o,

	output	logic								sync_o,
	output	logic								sclk_o,
	output	logic								sdi_o
);

	import calsoc_pkg::*;

	localparam int div_w = (spi_clk_div > 1) ? $clog2(spi_clk_div) : 1;
	localparam int bit_w = $clog2(dac_code_w);

	logic [dac_code_w-1:0]	shreg;
	logic [div_w-1:0]		div_cnt;
	logic [bit_w-1:0]		bit_cnt;
	logic					half_done;

	assign half_done = div_cnt == div_w'(spi_clk_div - 1);

	// Busy from the load request until sync is back high
	assign busy_o = load_i | ~sync_o;

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_o  <= 1'b1;
			sclk_o  <= 1'b0;
			sdi_o   <= 1'b0;
			shreg   <= '0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (sync_o) begin
			if (load_i) begin
				// First bit is set up before the first rising sclk
				sync_o  <= 1'b0;
				sclk_o  <= 1'b0;
				sdi_o   <= code_i[dac_code_w-1];
				shreg   <= code_i;
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else begin
			div_cnt <= half_done ? '0 : div_cnt + 1'b1;
			if (half_done) begin
				sclk_o <= ~sclk_o;
				// Falling edge, move on to the next bit
				if (sclk_o) begin
					if (bit_cnt == bit_w'(dac_code_w - 1)) begin
						sync_o <= 1'b1;
						sdi_o  <= 1'b0;
					end else begin
						sdi_o   <= shreg[dac_code_w-2];
						shreg   <= {shreg[dac_code_w-2:0], 1'b0};
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end
		end
	end

endmodule

/* logic/measure_unit.sv */
`timescale 1ns/10ps

module measure_unit (
	input	logic									wb_clk_i,
	input	logic									rst_n_i,

	input	logic									stb_i,
	input	logic									we_i,
	input	logic [31:0]							adr_i,
	input	logic [31:0]							dat_i,
	output	logic [31:0]							dat_o,
	output	logic									ack_o,

	input	logic									cmp_i,
	output	logic									dac_sync_o,
	output	logic									dac_sclk_o,
	output	logic									dac_sdi_o,
	output	logic [calsoc_pkg::delay_code_w-1:0]	delay_code_o,
	output	logic									delay_stb_o
);

	import calsoc_pkg::*;

	localparam int cnt_w = $clog2(dac_settle_cycles + strobe_hold_cycles);

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_settle,
		st_strobe
	} state_t;

	state_t					state;
	logic [cnt_w-1:0]		cnt;
	logic [dac_code_w-1:0]	dac_reg;
	logic [delay_code_w-1:0]	delay_reg;
	logic					result;
	logic					done;
	logic					busy;
	logic					spi_busy;
	logic [1:0]				reg_sel;
	logic					req;
	logic					start;

	assign reg_sel = adr_i[3:2];
	assign req     = stb_i & ~ack_o;
	assign busy    = state != st_idle;

	// Start is dropped while a measurement runs
	assign start = req & we_i & (reg_sel == mu_reg_ctrl) & dat_i[0] & ~busy;

	assign delay_code_o = delay_reg;

	//////////////////////////////////////////////////
	// Register access
	//////////////////////////////////////////////////

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o     <= 1'b0;
			dat_o     <= '0;
			dac_reg   <= '0;
			delay_reg <= '0;
		end else begin
			ack_o <= req;
			if (req && we_i) begin
				case (reg_sel)
					mu_reg_dac:   dac_reg   <= dat_i[dac_code_w-1:0];
					mu_reg_delay: delay_reg <= dat_i[delay_code_w-1:0];
					default:      ;
				endcase
			end
			if (req && !we_i) begin
				case (reg_sel)
					mu_reg_dac:    dat_o <= 32'(dac_reg);
					mu_reg_delay:  dat_o <= 32'(delay_reg);
					mu_reg_status: dat_o <= {29'b0, done, result, busy};
					default:       dat_o <= '0;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Measurement sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state       <= st_idle;
			cnt         <= '0;
			delay_stb_o <= 1'b0;
			result      <= 1'b0;
			done        <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_load;
						done  <= 1'b0;
					end
				end
				// DAC frame in flight
				st_load: begin
					if (!spi_busy) begin
						state <= st_settle;
						cnt   <= '0;
					end
				end
				st_settle: begin
					cnt <= cnt + 1'b1;
					if (cnt == cnt_w'(dac_settle_cycles - 1)) begin
						state       <= st_strobe;
						cnt         <= '0;
						delay_stb_o <= 1'b1;
					end
				end
				st_strobe: begin
					cnt <= cnt + 1'b1;
					// Last strobe cycle, take the comparator
					if (cnt == cnt_w'(strobe_hold_cycles - 1)) begin
						state       <= st_idle;
						delay_stb_o <= 1'b0;
						result      <= cmp_i;
						done        <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	dac_spi dac_spi0 (
		.wb_clk_i	(wb_clk_i),
		.rst_n_i	(rst_n_i),
		.load_i		(start),
		.code_i		(dac_reg),
		.busy_o		(spi_busy),
		.sync_o		(dac_sync_o),
		.sclk_o		(dac_sclk_o),
		.sdi_o		(dac_sdi_o)
	);

	a_stb_after_frame: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		delay_stb_o |-> dac_sync_o);

endmodule

/* logic/calsoc_core.sv */
`timescale 1ns/10ps

module calsoc_core (
	input	logic									wb_clk_i,
	input	logic									rst_n_i,

	// Master port
	input	logic									wb_cyc_i,
	input	logic									wb_stb_i,
	input	logic									wb_we_i,
	input	logic [31:0]							wb_adr_i,
	input	logic [31:0]							wb_dat_i,
	input	logic [3:0]								wb_sel_i,
	output	logic [31:0]							wb_dat_o,
	output	logic									wb_ack_o,
	output	logic									wb_err_o,

	// GPIO pins
	input	logic [calsoc_pkg::gpio_width-1:0]		gpio_i,
	output	logic [calsoc_pkg::gpio_width-1:0]		gpio_o,

	// Comparator, DAC and delay line
	input	logic									cmp_i,
	output	logic									dac_sync_o,
	output	logic									dac_sclk_o,
	output	logic									dac_sdi_o,
	output	logic [calsoc_pkg::delay_code_w-1:0]	delay_code_o,
	output	logic									delay_stb_o
);

	logic			ram_stb, gpio_stb, mu_stb;
	logic			ram_ack, gpio_ack, mu_ack;
	logic [31:0]	ram_dat, gpio_dat, mu_dat;

	//////////////////////////////////////////////////
	// Bus
	//////////////////////////////////////////////////

	wb_decoder dec0 (
		.wb_clk_i	(wb_clk_i),
		.rst_n_i	(rst_n_i),
		.wb_cyc_i	(wb_cyc_i),
		.wb_stb_i	(wb_stb_i),
		.wb_adr_i	(wb_adr_i),
		.wb_dat_o	(wb_dat_o),
		.wb_ack_o	(wb_ack_o),
		.wb_err_o	(wb_err_o),
		.ram_stb_o	(ram_stb),
		.ram_dat_i	(ram_dat),
		.ram_ack_i	(ram_ack),
		.gpio_stb_o	(gpio_stb),
		.gpio_dat_i	(gpio_dat),
		.gpio_ack_i	(gpio_ack),
		.mu_stb_o	(mu_stb),
		.mu_dat_i	(mu_dat),
		.mu_ack_i	(mu_ack)
	);

	//////////////////////////////////////////////////
	// Slaves
	//////////////////////////////////////////////////

	wb_ram ram0 (
		.wb_clk_i	(wb_clk_i),
		.rst_n_i	(rst_n_i),
		.stb_i		(ram_stb),
		.we_i		(wb_we_i),
		.adr_i		(wb_adr_i),
		.dat_i		(wb_dat_i),
		.sel_i		(wb_sel_i),
		.dat_o		(ram_dat),
		.ack_o		(ram_ack)
	);

	gpio_regs gpio0 (
		.wb_clk_i	(wb_clk_i),
		.rst_n_i	(rst_n_i),
		.stb_i		(gpio_stb),
		.we_i		(wb_we_i),
		.adr_i		(wb_adr_i),
		.dat_i		(wb_dat_i),
		.sel_i		(wb_sel_i),
		.dat_o		(gpio_dat),
		.ack_o		(gpio_ack),
		.gpio_i		(gpio_i),
		.gpio_o		(gpio_o)
	);

	// Measure unit has no byte lanes
	measure_unit mu0 (
		.wb_clk_i		(wb_clk_i),
		.rst_n_i		(rst_n_i),
		.stb_i			(mu_stb),
		.we_i			(wb_we_i),
		.adr_i			(wb_adr_i),
		.dat_i			(wb_dat_i),
		.dat_o			(mu_dat),
		.ack_o			(mu_ack),
		.cmp_i			(cmp_i),
		.dac_sync_o		(dac_sync_o),
		.dac_sclk_o		(dac_sclk_o),
		.dac_sdi_o		(dac_sdi_o),
		.delay_code_o	(delay_code_o),
		.delay_stb_o	(delay_stb_o)
	);

endmodule

/* tb/calsoc_tb.sv */
`timescale 1ns/10ps

module calsoc_tb;

	import calsoc_pkg::*;

	localparam int aw = $clog2(ram_words);

	// Run length budget, bus operations plus measurements, doubled twice
	localparam int op_cycles   = 4;
	localparam int meas_cycles = 2 * dac_code_w * spi_clk_div + dac_settle_cycles
		+ strobe_hold_cycles + 16;
	localparam int max_cycles  = 4 * (op_cycles * (ram_words + 600) + 21 * meas_cycles);

	logic							wb_clk;
	logic							rst_n;
	logic							wb_cyc;
	logic							wb_stb;
	logic							wb_we;
	logic [31:0]					wb_adr;
	logic [31:0]					wb_dat_w;
	logic [3:0]						wb_sel;
	logic [31:0]					wb_dat_r;
	logic							wb_ack;
	logic							wb_err;
	logic [gpio_width-1:0]			gpio_in;
	logic [gpio_width-1:0]			gpio_out;
	logic							cmp;
	logic							dac_sync;
	logic							dac_sclk;
	logic							dac_sdi;
	logic [delay_code_w-1:0]		delay_code;
	logic							delay_stb;

	// Reference model
	logic [31:0]					ram_model [ram_words];
	logic [gpio_width-1:0]			gpio_model;
	logic							gpio_check;

	logic [dac_code_w-1:0]			spi_shift;
	logic [dac_code_w-1:0]			spi_word;
	int								spi_bits;
	int								frames;
	int								stb_len;
	int								stb_pulses;
	int								cycles;
	int								value_errors;
	int								other_errors;
	integer							seed;

	calsoc_core dut0 (
		.wb_clk_i		(wb_clk),
		.rst_n_i		(rst_n),
		.wb_cyc_i		(wb_cyc),
		.wb_stb_i		(wb_stb),
		.wb_we_i		(wb_we),
		.wb_adr_i		(wb_adr),
		.wb_dat_i		(wb_dat_w),
		.wb_sel_i		(wb_sel),
		.wb_dat_o		(wb_dat_r),
		.wb_ack_o		(wb_ack),
		.wb_err_o		(wb_err),
		.gpio_i			(gpio_in),
		.gpio_o			(gpio_out),
		.cmp_i			(cmp),
		.dac_sync_o		(dac_sync),
		.dac_sclk_o		(dac_sclk),
		.dac_sdi_o		(dac_sdi),
		.delay_code_o	(delay_code),
		.delay_stb_o	(delay_stb)
	);

	initial begin
		wb_clk = 1'b0;
		forever #4 wb_clk = ~wb_clk;
	end

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
		input logic [31:0] got);
		$display("error %0t %s expected %h got %h", $time, sig, exp, got);
		value_errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("%0t %s", $time, msg);
		other_errors++;
	endtask

	// Stored contents depend on every address bit
	function automatic logic [31:0] fill_pattern(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0ff0;
	endfunction

	//////////////////////////////////////////////////
	// Bus tasks
	//////////////////////////////////////////////////

	task automatic bus_access(input logic wr, input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, output logic [31:0] rdat, output logic err);
		int waits;
		waits = 0;
		@(posedge wb_clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= wr;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		wb_sel   <= sel;
		do begin
			@(negedge wb_clk);
			waits++;
		end while (!wb_ack && !wb_err);
		rdat = wb_dat_r;
		err  = wb_err;
		if (wb_ack && wb_err)
			report_problem("ack and err were high together");
		if (waits != 2)
			report_problem("response did not come one cycle after the strobe");
		@(posedge wb_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		logic [31:0] rdat;
		logic err;
		bus_access(1'b1, adr, dat, sel, rdat, err);
		if (err)
			report_problem("write to a mapped address returned a bus error");
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
		logic err;
		bus_access(1'b0, adr, 32'h0, 4'hf, rdat, err);
		if (err)
			report_problem("read from a mapped address returned a bus error");
	endtask

	task automatic check_read(input string sig, input logic [31:0] adr,
		input logic [31:0] exp);
		logic [31:0] got;
		bus_read(adr, got);
		if (got !== exp)
			report_mismatch(sig, exp, got);
	endtask

	task automatic ram_write(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		logic [aw-1:0] idx;
		idx = adr[aw+1:2];
		bus_write(adr, dat, sel);
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				ram_model[idx][8*b +: 8] = dat[8*b +: 8];
		end
	endtask

	//////////////////////////////////////////////////
	// Measurement tasks
	//////////////////////////////////////////////////

	task automatic wait_idle(output logic [31:0] st);
		do begin
			bus_read(mu_base + 32'd12, st);
		end while (st[0]);
	endtask

	task automatic run_measurement(input logic [dac_code_w-1:0] code,
		input logic [delay_code_w-1:0] dly, input logic cmp_val);
		int frames0;
		int pulses0;
		logic [31:0] st;
		bus_write(mu_base, 32'(code), 4'hf);
		bus_write(mu_base + 32'd4, 32'(dly), 4'hf);
		check_read("wb_dat_o (dac)", mu_base, 32'(code));
		check_read("wb_dat_o (delay)", mu_base + 32'd4, 32'(dly));
		@(posedge wb_clk);
		cmp <= cmp_val;
		frames0 = frames;
		pulses0 = stb_pulses;
		bus_write(mu_base + 32'd8, 32'h1, 4'hf);
		wait_idle(st);
		// Done set, result from the comparator, busy clear
		if (st !== {29'b0, 1'b1, cmp_val, 1'b0})
			report_mismatch("wb_dat_o (status)", {29'b0, 1'b1, cmp_val, 1'b0}, st);
		if (frames != frames0 + 1)
			report_mismatch("dac frame count", 32'(frames0 + 1), 32'(frames));
		if (spi_word !== code)
			report_mismatch("dac_sdi_o word", 32'(code), 32'(spi_word));
		if (stb_pulses != pulses0 + 1)
			report_mismatch("delay_stb_o pulses", 32'(pulses0 + 1), 32'(stb_pulses));
		if (delay_code !== dly)
			report_mismatch("delay_code_o", 32'(dly), 32'(delay_code));
	endtask

	task automatic start_while_busy(input logic [dac_code_w-1:0] first,
		input logic [dac_code_w-1:0] second);
		int frames0;
		logic [31:0] st;
		bus_write(mu_base, 32'(first), 4'hf);
		frames0 = frames;
		bus_write(mu_base + 32'd8, 32'h1, 4'hf);
		bus_write(mu_base, 32'(second), 4'hf);
		bus_write(mu_base + 32'd8, 32'h1, 4'hf);
		bus_read(mu_base + 32'd12, st);
		if (!st[0])
			report_problem("measurement ended before the second start was written");
		wait_idle(st);
		repeat (4 * spi_clk_div) @(posedge wb_clk);
		if (dac_sync !== 1'b1)
			report_problem("a second DAC frame started after a start while busy");
		if (frames != frames0 + 1)
			report_mismatch("dac frame count", 32'(frames0 + 1), 32'(frames));
		if (spi_word !== first)
			report_mismatch("dac_sdi_o word", 32'(first), 32'(spi_word));
		check_read("wb_dat_o (dac)", mu_base, 32'(second));
	endtask

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////

	// DAC receiver, samples on rising sclk
	always @(posedge dac_sclk) begin
		if (!dac_sync) begin
			spi_shift = {spi_shift[dac_code_w-2:0], dac_sdi};
			spi_bits++;
		end
	end

	always @(posedge dac_sync) begin
		if (rst_n) begin
			if (spi_bits != dac_code_w)
				report_problem("DAC frame did not carry the full code width");
			spi_word = spi_shift;
			spi_bits = 0;
			frames++;
		end
	end

	// Strobe width in clock cycles
	always @(negedge wb_clk) begin
		if (rst_n) begin
			if (delay_stb) begin
				stb_len++;
			end else if (stb_len != 0) begin
				if (stb_len != strobe_hold_cycles)
					report_mismatch("delay_stb_o width", strobe_hold_cycles, stb_len);
				stb_pulses++;
				stb_len = 0;
			end
		end
	end

	// GPIO output must already hold the written value in the ack cycle
	always @(negedge wb_clk) begin
		if (gpio_check && wb_ack && gpio_out !== gpio_model)
			report_mismatch("gpio_o", 32'(gpio_model), 32'(gpio_out));
	end

	always @(posedge wb_clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("run stopped after %0d cycles without reaching the end", cycles);
			$display("value errors %0d, other errors %0d", value_errors, other_errors);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] adr;
		logic [31:0] rdat;
		logic err;
		seed         = 32'h0fc2_906b;
		cycles       = 0;
		value_errors = 0;
		other_errors = 0;
		frames       = 0;
		spi_bits     = 0;
		stb_len      = 0;
		stb_pulses   = 0;
		gpio_model   = '0;
		gpio_check   = 1'b0;
		rst_n    <= 1'b0;
		wb_cyc   <= 1'b0;
		wb_stb   <= 1'b0;
		wb_we    <= 1'b0;
		wb_adr   <= '0;
		wb_dat_w <= '0;
		wb_sel   <= '0;
		gpio_in  <= '0;
		cmp      <= 1'b0;
		repeat (3) @(posedge wb_clk);
		rst_n <= 1'b1;

		// Idle levels before any access
		@(negedge wb_clk);
		if (wb_ack !== 1'b0)
			report_mismatch("wb_ack_o", 32'h0, 32'(wb_ack));
		if (wb_err !== 1'b0)
			report_mismatch("wb_err_o", 32'h0, 32'(wb_err));
		if (dac_sync !== 1'b1)
			report_mismatch("dac_sync_o", 32'h1, 32'(dac_sync));
		if (dac_sclk !== 1'b0)
			report_mismatch("dac_sclk_o", 32'h0, 32'(dac_sclk));
		if (dac_sdi !== 1'b0)
			report_mismatch("dac_sdi_o", 32'h0, 32'(dac_sdi));
		if (delay_stb !== 1'b0)
			report_mismatch("delay_stb_o", 32'h0, 32'(delay_stb));
		if (delay_code !== '0)
			report_mismatch("delay_code_o", 32'h0, 32'(delay_code));
		if (gpio_out !== '0)
			report_mismatch("gpio_o", 32'h0, 32'(gpio_out));
		check_read("wb_dat_o (dac)", mu_base, 32'h0);
		check_read("wb_dat_o (delay)", mu_base + 32'd4, 32'h0);
		check_read("wb_dat_o (status)", mu_base + 32'd12, 32'h0);
		check_read("wb_dat_o (gpio out)", gpio_base, 32'h0);

		// Fill the RAM so every word has a known value
		for (int i = 0; i < ram_words; i++) begin
			adr = ram_base + 32'(4 * i);
			ram_write(adr, fill_pattern(adr), 4'hf);
		end

		// Random byte-lane writes, each followed by a random read
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			d = $random(seed);
			ram_write(ram_base | (r & 32'h00ff_fffc), d, r[31:28]);
			r = $random(seed);
			adr = ram_base | (r & 32'h00ff_fffc);
			check_read("wb_dat_o (ram)", adr, ram_model[adr[aw+1:2]]);
		end

		// GPIO output register and input synchronizer
		for (int n = 0; n < 8; n++) begin
			r = $random(seed);
			if (r[8])
				gpio_model = r[gpio_width-1:0];
			gpio_check = 1'b1;
			bus_write(gpio_base, r, r[11:8]);
			gpio_check = 1'b0;
			check_read("wb_dat_o (gpio out)", gpio_base, 32'(gpio_model));
			@(posedge wb_clk);
			gpio_in <= r[31:24];
			repeat (3) @(posedge wb_clk);
			check_read("wb_dat_o (gpio in)", gpio_base + 32'd4, 32'(r[31:24]));
			bus_write(gpio_base + 32'd4, ~r, 4'hf);
			check_read("wb_dat_o (gpio out)", gpio_base, 32'(gpio_model));
		end

		// Unmapped addresses answer with err only
		for (int n = 0; n < 12; n++) begin
			r = $random(seed);
			d = $random(seed);
			case (r[1:0])
				2'd0:    adr = {8'h03, r[31:8]};
				2'd1:    adr = {8'h00, r[31:8]};
				2'd2:    adr = gpio_base | 32'h0000_0040 | (r & 32'h00ff_ff80);
				default: adr = {8'hf5, r[31:8]};
			endcase
			bus_access(r[2], adr, d, 4'hf, rdat, err);
			if (!err)
				report_problem("unmapped address did not return a bus error");
			if (rdat !== 32'h0)
				report_mismatch("wb_dat_o (unmapped)", 32'h0, rdat);
			adr = ram_base | (adr & 32'h0000_03fc);
			check_read("wb_dat_o (ram)", adr, ram_model[adr[aw+1:2]]);
		end

		for (int n = 0; n < 20; n++) begin
			r = $random(seed);
			d = $random(seed);
			run_measurement(r[dac_code_w-1:0], d[delay_code_w-1:0], d[31]);
		end

		r = $random(seed);
		start_while_busy(r[dac_code_w-1:0], r[31:32-dac_code_w]);

		@(posedge wb_clk);
		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* src.f */
logic/calsoc_pkg.sv
logic/wb_decoder.sv
logic/wb_ram.sv
logic/gpio_regs.sv
logic/dac_spi.sv
logic/measure_unit.sv
logic/calsoc_core.sv
tb/calsoc_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module calsoc_tb -f src.f -o calsoc_sim

out=$(./obj_dir/calsoc_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'test passed'; then
	exit 0
fi
exit 1
